//--- src/image_capture_macros.svh
`ifndef IMAGE_CAPTURE_MACROS_SVH
`define IMAGE_CAPTURE_MACROS_SVH

// ==================================================
// Frame geometry
// ==================================================
`define FRAME_W    64          // Raw active window width
`define FRAME_H    64          // Raw active window height

`define IMG_W      32          // Gray image after 2x2 reduction
`define IMG_H      32
`define IMG_WORDS  1024        // IMG_W * IMG_H

// ==================================================
// Register map in word addresses
// ==================================================
`define REG_CTRL   10'd0       // Write only
`define REG_STATUS 10'd1
`define REG_FRAMES 10'd2
`define BAD_READ   32'h0000dead

`endif

//--- src/image_capture_pkg.sv
`include "image_capture_macros.svh"

package image_capture_pkg;

    // One sensor sample from the D5M
    typedef logic [11:0] raw_pix_t;

    // Reduced gray pixel
    typedef logic [7:0] gray_pix_t;

    // Word address into the gray image
    typedef logic [$clog2(`IMG_W * `IMG_H)-1:0] img_addr_t;

    // Raw x or y position
    // One extra bit so the count can run past the window
    typedef logic [$clog2(`FRAME_W):0] coord_t;

    // Wishbone data word
    typedef logic [31:0] wb_word_t;

endpackage

//--- src/pixel_ram.sv
`timescale 1ns/1ns

module pixel_ram #(
    parameter type payload_t = logic [7:0],  // Item stored per address
    parameter int  DEPTH     = 64
) (
    input  logic                     D5M_PIXLCLK,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  payload_t                 wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output payload_t                 rdata
);

    payload_t mem [DEPTH];  // Storage array

    // One write and one read per clock
    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (we)
            mem[waddr] <= wdata;
        // Registered read port
        // Same address as a write gives the old item
        rdata <= mem[raddr];
    end

endmodule

//--- src/ccd_capture.sv
`timescale 1ns/1ns
`include "image_capture_macros.svh"

module ccd_capture import image_capture_pkg::*; (
    input  logic        D5M_PIXLCLK,
    input  logic        rst_n,
    input  raw_pix_t    d5m_d,
    input  logic        d5m_fval,
    input  logic        d5m_lval,
    input  logic        start_req,     // One cycle pulse from the bus
    input  logic        stop_req,      // One cycle pulse from the bus
    output raw_pix_t    pix_data,
    output logic        pix_valid,
    output coord_t      pix_x,
    output coord_t      pix_y,
    output logic        frame_end,
    output logic        capturing,
    output logic [15:0] frame_count
);

    typedef enum logic [1:0] {
        CAP_IDLE,
        CAP_ARMED,     // Waiting for the next frame start
        CAP_ACTIVE
    } cap_state_t;

    cap_state_t state;
    logic       stop_pending;
    logic       stop_next;
    raw_pix_t   d_r;
    logic       fval_r;
    logic       fval_d;
    logic       lval_r;
    logic       lval_d;
    coord_t     x_cnt;
    coord_t     y_cnt;
    logic       fval_rise;
    logic       fval_fall;
    logic       lval_fall;
    logic       in_window;
    logic       take_pix;

    // ==================================================
    // Sensor input stage and edge detect
    // ==================================================
    assign fval_rise = fval_r & ~fval_d;
    assign fval_fall = ~fval_r & fval_d;
    assign lval_fall = ~lval_r & lval_d;   // End of a line

    always_ff @(posedge D5M_PIXLCLK)
    begin
        d_r      <= d5m_d;      // Sample edge k
        pix_data <= d_r;        // Presented at edge k+1
        pix_x    <= x_cnt;
        pix_y    <= y_cnt;
    end

    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (!rst_n)
        begin
            fval_r <= 1'b0;
            fval_d <= 1'b0;
            lval_r <= 1'b0;
            lval_d <= 1'b0;
        end
        else
        begin
            fval_r <= d5m_fval;
            fval_d <= fval_r;
            lval_r <= d5m_lval;
            lval_d <= lval_r;
        end
    end

    // ==================================================
    // Pixel position counters
    // ==================================================
    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (!rst_n)
        begin
            x_cnt <= '0;
            y_cnt <= '0;
        end
        else
        begin
            if (!lval_r)
                x_cnt <= '0;                        // Clear between lines
            else if (x_cnt != coord_t'(`FRAME_W))
                x_cnt <= x_cnt + 7'd1;              // Saturates past the window
            if (!fval_r)
                y_cnt <= '0;                        // Clear in vertical blanking
            else if (lval_fall && y_cnt != coord_t'(`FRAME_H))
                y_cnt <= y_cnt + 7'd1;
        end
    end

    // ==================================================
    // Start and stop control
    // ==================================================
    assign in_window = (x_cnt < coord_t'(`FRAME_W)) && (y_cnt < coord_t'(`FRAME_H));
    // First pixel may land on the same edge that starts the frame
    assign take_pix  = (state == CAP_ACTIVE) || ((state == CAP_ARMED) && fval_rise);
    // Latest request wins, start cancels a pending stop
    assign stop_next = start_req ? 1'b0 : (stop_req ? 1'b1 : stop_pending);

    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (!rst_n)
        begin
            state        <= CAP_IDLE;
            stop_pending <= 1'b0;
            frame_count  <= '0;
            frame_end    <= 1'b0;
            pix_valid    <= 1'b0;
        end
        else
        begin
            frame_end <= 1'b0;
            pix_valid <= fval_r && lval_r && in_window && take_pix;
            case (state)
                CAP_IDLE:
                    if (start_req)
                        state <= CAP_ARMED;
                CAP_ARMED:
                    if (stop_req)
                        state <= CAP_IDLE;          // Cancel before any frame
                    else if (fval_rise)
                        state <= CAP_ACTIVE;
                CAP_ACTIVE:
                begin
                    stop_pending <= stop_next;
                    if (fval_fall)
                    begin
                        frame_count <= frame_count + 16'd1;
                        frame_end   <= 1'b1;
                        if (stop_next)
                        begin
                            state        <= CAP_IDLE;   // Frame done then stop
                            stop_pending <= 1'b0;
                        end
                    end
                end
                default:
                    state <= CAP_IDLE;
            endcase
        end
    end

    assign capturing = (state == CAP_ACTIVE);

endmodule

//--- src/raw_to_gray.sv
`timescale 1ns/1ns
`include "image_capture_macros.svh"

module raw_to_gray import image_capture_pkg::*; (
    input  logic      D5M_PIXLCLK,
    input  logic      rst_n,
    input  raw_pix_t  pix_data,
    input  logic      pix_valid,
    input  coord_t    pix_x,
    input  coord_t    pix_y,
    output logic      gray_we,
    output img_addr_t gray_addr,
    output gray_pix_t gray_data
);

    localparam int LB_AW = $clog2(`FRAME_W);    // Line buffer address width

    logic             lb_we;
    logic [LB_AW-1:0] lb_waddr;
    logic [LB_AW-1:0] lb_raddr;
    raw_pix_t         lb_rdata;
    coord_t           rd_x;
    raw_pix_t         left_pix;     // Even column of the current cell
    raw_pix_t         above_left;   // Row above at the even column
    logic [13:0]      cell_sum;
    logic             cell_done;

    // ==================================================
    // Line buffer for the even row of each cell
    // ==================================================
    assign lb_we    = pix_valid & ~pix_y[0];     // Even rows only
    assign lb_waddr = pix_x[LB_AW-1:0];

    // Read one column ahead of the incoming pixel
    // Idle address 0 preloads column 0 before an odd row starts
    assign rd_x     = pix_valid ? pix_x + 7'd1 : '0;
    assign lb_raddr = rd_x[LB_AW-1:0];           // Wraps harmlessly after x 63

    pixel_ram #(
        .payload_t (raw_pix_t),
        .DEPTH     (`FRAME_W)
    ) u_line_buf (
        .D5M_PIXLCLK (D5M_PIXLCLK),
        .we          (lb_we),
        .waddr       (lb_waddr),
        .wdata       (pix_data),
        .raddr       (lb_raddr),
        .rdata       (lb_rdata)
    );

    // ==================================================
    // Cell accumulation
    // ==================================================
    // Hold the left half of the cell
    // lb_rdata here is the row above at this same even column
    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (pix_valid && !pix_x[0])
        begin
            left_pix   <= pix_data;
            above_left <= lb_rdata;
        end
    end

    // At odd x lb_rdata is the row above at odd x
    assign cell_sum  = 14'(left_pix) + 14'(above_left) + 14'(lb_rdata) + 14'(pix_data);
    assign cell_done = pix_valid & pix_x[0] & pix_y[0];     // Last sample of the cell

    // Gray word out two edges after its last raw sample
    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (cell_done)
        begin
            gray_addr <= img_addr_t'(pix_y[5:1] * `IMG_W + pix_x[5:1]);  // (y/2)*32 + x/2
            gray_data <= cell_sum[13:6];     // Sum of four divided by 64
        end
    end

    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (!rst_n)
            gray_we <= 1'b0;
        else
            gray_we <= cell_done;
    end

endmodule

//--- src/capture_wb_slave.sv
`timescale 1ns/1ns
`include "image_capture_macros.svh"

module capture_wb_slave import image_capture_pkg::*; (
    input  logic        D5M_PIXLCLK,
    input  logic        rst_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [10:0] wb_adr,
    input  wb_word_t    wb_dat_w,
    input  logic        capturing,
    input  logic [15:0] frame_count,
    input  gray_pix_t   img_rdata,
    output wb_word_t    wb_dat_r,
    output logic        wb_ack,
    output logic        start_req,
    output logic        stop_req,
    output img_addr_t   img_raddr
);

    logic       phase;       // Set while an access waits for its ack
    logic       req_new;
    logic       img_sel;
    logic [9:0] reg_adr;
    logic       ctrl_wr;
    wb_word_t   reg_rdata;

    // ==================================================
    // Address decode
    // ==================================================
    assign img_sel   = wb_adr[10];           // Upper half is the image window
    assign reg_adr   = wb_adr[9:0];
    assign img_raddr = wb_adr[9:0];          // RAM read starts on the first edge

    // New access only when idle and not in the ack cycle
    assign req_new = wb_cyc & wb_stb & ~phase & ~wb_ack;
    assign ctrl_wr = req_new & wb_we & ~img_sel & (reg_adr == `REG_CTRL);

    always_comb
    begin
        case (reg_adr)
            `REG_STATUS: reg_rdata = {31'd0, capturing};
            `REG_FRAMES: reg_rdata = {16'd0, frame_count};
            // Control is write only and reads like an empty slot
            default:     reg_rdata = `BAD_READ;
        endcase
    end

    // ==================================================
    // Phase counter and ack
    // ==================================================
    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (!rst_n)
        begin
            phase     <= 1'b0;
            wb_ack    <= 1'b0;
            start_req <= 1'b0;
            stop_req  <= 1'b0;
        end
        else
        begin
            wb_ack    <= 1'b0;
            start_req <= ctrl_wr & wb_dat_w[0];   // One pulse per access
            stop_req  <= ctrl_wr & wb_dat_w[1];
            if (req_new)
                phase <= 1'b1;
            else if (phase)
            begin
                phase  <= 1'b0;
                wb_ack <= wb_cyc & wb_stb;        // No ack for an abandoned cycle
            end
        end
    end

    // Read data lands with the ack
    always_ff @(posedge D5M_PIXLCLK)
    begin
        if (phase)
        begin
            if (img_sel)
                wb_dat_r <= {24'd0, img_rdata};   // Zero extended pixel
            else
                wb_dat_r <= reg_rdata;
        end
    end

endmodule

//--- src/image_capture_top.sv
`timescale 1ns/1ns
`include "image_capture_macros.svh"

module image_capture_top import image_capture_pkg::*; (
    input  logic        D5M_PIXLCLK,
    input  logic        rst_n,

    // D5M sensor
    input  raw_pix_t    D5M_D,
    input  logic        D5M_FVAL,
    input  logic        D5M_LVAL,

    // Wishbone classic slave
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [10:0] wb_adr,
    input  wb_word_t    wb_dat_w,
    output wb_word_t    wb_dat_r,
    output logic        wb_ack
);

    // ==================================================
    // Interconnect
    // ==================================================
    raw_pix_t    pix_data;
    logic        pix_valid;
    coord_t      pix_x;
    coord_t      pix_y;
    logic        capturing;
    logic [15:0] frame_count;
    logic        start_req;
    logic        stop_req;
    logic        gray_we;
    img_addr_t   gray_addr;
    gray_pix_t   gray_data;
    img_addr_t   img_raddr;
    gray_pix_t   img_rdata;

    // Sensor front end and capture control
    ccd_capture u_ccd_capture (
        .D5M_PIXLCLK (D5M_PIXLCLK),
        .rst_n       (rst_n),
        .d5m_d       (D5M_D),
        .d5m_fval    (D5M_FVAL),
        .d5m_lval    (D5M_LVAL),
        .start_req   (start_req),
        .stop_req    (stop_req),
        .pix_data    (pix_data),
        .pix_valid   (pix_valid),
        .pix_x       (pix_x),
        .pix_y       (pix_y),
        .frame_end   (),              // Gray path keys off pix_valid alone
        .capturing   (capturing),
        .frame_count (frame_count)
    );

    raw_to_gray u_raw_to_gray (
        .D5M_PIXLCLK (D5M_PIXLCLK),
        .rst_n       (rst_n),
        .pix_data    (pix_data),
        .pix_valid   (pix_valid),
        .pix_x       (pix_x),
        .pix_y       (pix_y),
        .gray_we     (gray_we),
        .gray_addr   (gray_addr),
        .gray_data   (gray_data)
    );

    // 32x32 gray image
    pixel_ram #(
        .payload_t (gray_pix_t),
        .DEPTH     (`IMG_WORDS)
    ) u_image_ram (
        .D5M_PIXLCLK (D5M_PIXLCLK),
        .we          (gray_we),
        .waddr       (gray_addr),
        .wdata       (gray_data),
        .raddr       (img_raddr),
        .rdata       (img_rdata)
    );

    capture_wb_slave u_wb_slave (
        .D5M_PIXLCLK (D5M_PIXLCLK),
        .rst_n       (rst_n),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .capturing   (capturing),
        .frame_count (frame_count),
        .img_rdata   (img_rdata),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .start_req   (start_req),
        .stop_req    (stop_req),
        .img_raddr   (img_raddr)
    );

endmodule

//--- tb/tb_image_capture.sv
`timescale 1ns/1ns
`include "image_capture_macros.svh"

module tb_image_capture import image_capture_pkg::*; ();

    localparam int MAX_CYCLES = 6 * (`FRAME_H * 75 + 20) + 20000;  // Frames plus bus traffic
    localparam int M_IDLE   = 0;
    localparam int M_ARMED  = 1;
    localparam int M_ACTIVE = 2;

    logic        D5M_PIXLCLK;
    logic        rst_n;
    raw_pix_t    D5M_D;
    logic        D5M_FVAL;
    logic        D5M_LVAL;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [10:0] wb_adr;
    wb_word_t    wb_dat_w;
    wb_word_t    wb_dat_r;
    logic        wb_ack;

    raw_pix_t    raw_frame [`FRAME_H][`FRAME_W];  // Last frame sent
    gray_pix_t   exp_img [`IMG_WORDS];            // Gray image of the last stored frame
    int          mdl_state;
    bit          mdl_stop;                        // Stop waiting for frame end
    bit          frame_stored;
    int          mdl_frames;
    int          err_count;
    int          tests_run;
    int          tests_failed;
    int          cycle_cnt;

    image_capture_top u_dut (.*);

    initial
    begin
        D5M_PIXLCLK = 1'b0;
        forever #100 D5M_PIXLCLK = ~D5M_PIXLCLK;   // 200 ns period
    end

    // Hard limit so a stuck handshake cannot hang the run
    always @(posedge D5M_PIXLCLK)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES)
        begin
            $display("Timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ==================================================
    // Wishbone master
    // ==================================================
    task automatic wb_access(input logic we, input logic [10:0] adr, input wb_word_t wdat,
                             output wb_word_t rdat);
        @(posedge D5M_PIXLCLK);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdat;
        do
            @(negedge D5M_PIXLCLK);     // Ack sampled mid cycle
        while (!wb_ack);
        rdat = wb_dat_r;
        @(posedge D5M_PIXLCLK);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_read(input logic [10:0] adr, output wb_word_t rdat);
        wb_access(1'b0, adr, '0, rdat);
    endtask

    task automatic wb_write(input logic [10:0] adr, input wb_word_t wdat);
        wb_word_t unused;
        wb_access(1'b1, adr, wdat, unused);
    endtask

    // Control write plus the matching reference model update
    task automatic send_control(input bit start, input bit stop);
        if (start)
        begin
            mdl_stop = 1'b0;                    // Start cancels a pending stop
            if (mdl_state == M_IDLE)
                mdl_state = M_ARMED;
        end
        if (stop && mdl_state == M_ARMED)
            mdl_state = M_IDLE;
        else if (stop && mdl_state == M_ACTIVE)
            mdl_stop = 1'b1;                    // Finish the frame first
        wb_write(11'(`REG_CTRL), {30'd0, stop, start});
    endtask

    // ==================================================
    // Sensor frame and reference model
    // ==================================================
    task automatic send_frame();
        logic [13:0] sum;
        if (mdl_state == M_ARMED)
            mdl_state = M_ACTIVE;
        frame_stored = (mdl_state == M_ACTIVE);
        repeat (2 + $urandom % 8) @(posedge D5M_PIXLCLK);   // Vertical blanking
        D5M_FVAL <= 1'b1;
        for (int y = 0; y < `FRAME_H; y++)
        begin
            repeat (2 + $urandom % 8) @(posedge D5M_PIXLCLK);   // Horizontal blanking
            for (int x = 0; x < `FRAME_W; x++)
            begin
                @(posedge D5M_PIXLCLK);
                raw_frame[y][x] = raw_pix_t'($urandom);
                D5M_LVAL <= 1'b1;
                D5M_D    <= raw_frame[y][x];
            end
            @(posedge D5M_PIXLCLK);
            D5M_LVAL <= 1'b0;
        end
        repeat (2 + $urandom % 8) @(posedge D5M_PIXLCLK);
        D5M_FVAL <= 1'b0;
        repeat (4) @(posedge D5M_PIXLCLK);  // Let the last gray write land
        if (frame_stored)
        begin
            mdl_frames++;
            for (int cy = 0; cy < `IMG_H; cy++)
            begin
                for (int cx = 0; cx < `IMG_W; cx++)
                begin
                    sum = raw_frame[2*cy][2*cx] + raw_frame[2*cy][2*cx+1]
                        + raw_frame[2*cy+1][2*cx] + raw_frame[2*cy+1][2*cx+1];
                    exp_img[cy*`IMG_W + cx] = sum[13:6];   // Sum of cell divided by 64
                end
            end
            if (mdl_stop)
            begin
                mdl_state = M_IDLE;
                mdl_stop  = 1'b0;
            end
        end
    endtask

    // ==================================================
    // Checking helpers
    // ==================================================
    task automatic report_mismatch(input string what, input wb_word_t got, input wb_word_t exp);
        err_count++;
        $display("Fail at %0t ns: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
    endtask

    task automatic check_registers(input string tag);
        wb_word_t rd;
        wb_read(11'(`REG_STATUS), rd);
        if (rd !== {31'd0, mdl_state == M_ACTIVE})
            report_mismatch({tag, " status"}, rd, {31'd0, mdl_state == M_ACTIVE});
        wb_read(11'(`REG_FRAMES), rd);
        if (rd !== wb_word_t'(mdl_frames))
            report_mismatch({tag, " frames"}, rd, wb_word_t'(mdl_frames));
    endtask

    task automatic compare_image(input string tag);
        wb_word_t rd;
        for (int i = 0; i < `IMG_WORDS; i++)
        begin
            wb_read(11'h400 | 11'(i), rd);
            if (rd !== {24'd0, exp_img[i]})
                report_mismatch($sformatf("%s pixel %0d", tag, i), rd, {24'd0, exp_img[i]});
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (err_count == errs_before)
            $display("%s: passed", name);
        else
        begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial
    begin
        int       errs;
        int       k;
        wb_word_t rd;
        void'($urandom(32'h491e));
        rst_n = 1'b0;
        D5M_D = '0;
        D5M_FVAL = 1'b0;
        D5M_LVAL = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        mdl_state = M_IDLE;
        mdl_stop = 1'b0;
        mdl_frames = 0;
        err_count = 0;
        tests_run = 0;
        tests_failed = 0;
        cycle_cnt = 0;
        repeat (8) @(posedge D5M_PIXLCLK);
        rst_n <= 1'b1;

        errs = err_count;           // Reset values and undefined register
        check_registers("reset");
        wb_read(11'd5, rd);
        if (rd !== `BAD_READ)
            report_mismatch("register 5", rd, `BAD_READ);
        end_test("Test 1 reset values", errs);

        errs = err_count;           // No start, nothing captured
        send_frame();
        check_registers("no start");
        end_test("Test 2 frame without start", errs);

        errs = err_count;
        send_control(1'b1, 1'b0);
        send_frame();
        send_control(1'b0, 1'b1);
        compare_image("single frame");
        check_registers("single frame");
        end_test("Test 3 single frame", errs);

        errs = err_count;           // Start cancels the pending stop
        send_control(1'b1, 1'b0);
        send_frame();
        fork
            send_frame();
            check_registers("between frames");
        join
        compare_image("second frame");
        check_registers("two frames");
        end_test("Test 4 back to back frames", errs);

        errs = err_count;
        send_control(1'b1, 1'b0);
        fork
            send_frame();
            begin
                repeat (1500) @(posedge D5M_PIXLCLK);   // Stop lands mid frame
                send_control(1'b0, 1'b1);
            end
        join
        send_frame();               // Should be dropped
        compare_image("after stop");
        check_registers("after stop");
        end_test("Test 5 stop during frame", errs);

        errs = err_count;           // Image window is read only
        k = $urandom % `IMG_WORDS;
        wb_write(11'h400 | 11'(k), ~{24'd0, exp_img[k]});
        wb_read(11'h400 | 11'(k), rd);
        if (rd !== {24'd0, exp_img[k]})
            report_mismatch("image write", rd, {24'd0, exp_img[k]});
        end_test("Test 6 image write ignored", errs);

        $display("Tests run %0d, failed %0d, check errors %0d",
                 tests_run, tests_failed, err_count);
        if (err_count == 0 && tests_failed == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

//--- list.f
+incdir+src
src/image_capture_pkg.sv
src/pixel_ram.sv
src/ccd_capture.sv
src/raw_to_gray.sv
src/capture_wb_slave.sv
src/image_capture_top.sv
tb/tb_image_capture.sv
